/* Bender.yml */
package:
  name: fetch_unit

export_include_dirs:
  - hw

sources:
  - hw/fetch_pkg.sv
  - hw/branch_predecode.sv
  - hw/gshare_predictor.sv
  - hw/return_stack.sv
  - hw/next_pc_select.sv
  - hw/fetch_unit.sv
  - target: simulation
    files:
      - tb/fetch_unit_tb.sv

/* filelist.f */
+incdir+hw
hw/fetch_pkg.sv
hw/branch_predecode.sv
hw/gshare_predictor.sv
hw/return_stack.sv
hw/next_pc_select.sv
hw/fetch_unit.sv
tb/fetch_unit_tb.sv

/* hw/branch_predecode.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module branch_predecode (
  input  logic [`XLEN-1:0]     inst_i,
  input  logic [`XLEN-1:0]     pc_i,
  output fetch_pkg::predecode_t pdec_o
);

  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [4:0]       rd;
  logic [4:0]       rs1;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_sel;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign rd     = inst_i[11:7];
  assign rs1    = inst_i[19:15];

  // J and B immediates, sign taken from bit 31
  assign imm_j = {{(`XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b = {{(`XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  always_comb begin
    pdec_o.kind      = fetch_pkg::JK_NONE;
    pdec_o.is_return = 1'b0;
    imm_sel          = '0;
    case (opcode)
      OPC_JAL: begin
        pdec_o.kind = fetch_pkg::JK_JAL;
        imm_sel     = imm_j;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          pdec_o.kind = fetch_pkg::JK_JALR;
          // ret idiom: no link, source is ra or t0
          pdec_o.is_return = (rd == 5'd0) && ((rs1 == 5'd1) || (rs1 == 5'd5));
        end
      end
      OPC_BRANCH: begin
        pdec_o.kind = fetch_pkg::JK_BRANCH;
        imm_sel     = imm_b;
      end
      default: ; // not a control transfer
    endcase
    // one adder, jalr target needs rs1 so it stays at pc
    pdec_o.target = pc_i + imm_sel;
  end

endmodule

/* hw/fetch_pkg.sv */
`include "fetch_settings.svh"

package fetch_pkg;

  // jump type encoding shared with execute
  typedef enum logic [1:0] {
    JK_NONE   = 2'b00,
    JK_JAL    = 2'b01,
    JK_JALR   = 2'b10,
    JK_BRANCH = 2'b11
  } jump_kind_e;

  // predecoder result for the word in fetch
  typedef struct packed {
    jump_kind_e       kind;
    logic             is_return; // jalr x0, 0(ra/t0)
    logic [`XLEN-1:0] target;    // pc + imm, pc for non-control words
  } predecode_t;

  // resolution reported by execute
  typedef struct packed {
    logic               valid;
    jump_kind_e         kind;
    logic               taken;   // actual direction
    logic [`XLEN-1:0]   pc;      // pc of the resolved jump
    logic [`HISLEN-1:0] history; // history seen at prediction time
  } bp_update_t;

  // travels with the instruction through IF/ID to execute
  typedef struct packed {
    logic               taken;
    logic [`HISLEN-1:0] history;
  } prediction_t;

endpackage

/* hw/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// datapath width
`define XLEN 32

// global history length in bits
`define HISLEN 8

// direction counter table, indexed by pc[7:2] ^ history[5:0]
`define BHT_ENTRIES 64

// return address stack entries
`define RAS_DEPTH 4

// trap bus to IF/ID
`define TRAP_LEN 16
`define TRAP_INST_ADDR_MISALIGNED 0
`define TRAP_INST_ACCESS_FAULT 1

`endif

/* hw/fetch_unit.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_unit (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic [`XLEN-1:0]       inst_addr_i,      // from pc register
  input  logic [`XLEN-1:0]       if_rdata_i,
  input  logic                   if_rdata_valid_i, // memory data ready
  input  logic                   if_rerr_i,        // bus error on fetch
  input  fetch_pkg::bp_update_t  update_i,         // from execute
  input  logic                   ex_stall_i,
  input  logic                   ras_push_i,       // call in decode
  input  logic [`XLEN-1:0]       ras_push_addr_i,  // its link address
  output logic [`XLEN-1:0]       inst_addr_o,      // to IF/ID
  output logic [`XLEN-1:0]       inst_data_o,
  output logic [`TRAP_LEN-1:0]   trap_bus_o,
  output logic                   ram_stall_o,
  output logic [`XLEN-1:0]       bpu_pc_o,         // to pc register
  output logic                   bpu_pc_valid_o,
  output fetch_pkg::prediction_t pred_o            // to execute via IF/ID
);

  fetch_pkg::predecode_t pdec;
  logic                  gs_taken;
  logic [`HISLEN-1:0]    gs_history;
  logic [`XLEN-1:0]      ras_top;
  logic                  ras_empty;
  logic                  ras_pop;
  logic                  ram_stall;

  // hold the pipeline until memory returns the word
  assign ram_stall   = !if_rdata_valid_i;
  assign ram_stall_o = ram_stall;

  assign inst_addr_o = inst_addr_i;
  assign inst_data_o = if_rdata_i;

  always_comb begin
    trap_bus_o = '0;
    trap_bus_o[`TRAP_INST_ADDR_MISALIGNED] = |inst_addr_i[1:0];
    trap_bus_o[`TRAP_INST_ACCESS_FAULT]    = if_rdata_valid_i & if_rerr_i; // error only with data
  end

  branch_predecode branch_predecode_inst (
    .inst_i (if_rdata_i),
    .pc_i   (inst_addr_i),
    .pdec_o (pdec)
  );

  gshare_predictor gshare_predictor_inst (
    .clk       (clk),
    .rst_i     (rst_i),
    .pc_i      (inst_addr_i),
    .update_i  (update_i),
    .stall_i   (ex_stall_i),
    .taken_o   (gs_taken),
    .history_o (gs_history)
  );

  return_stack return_stack_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .push_i      (ras_push_i), // not gated by the fetch stall
    .push_addr_i (ras_push_addr_i),
    .pop_i       (ras_pop),
    .top_o       (ras_top),
    .empty_o     (ras_empty)
  );

  next_pc_select next_pc_select_inst (
    .pc_i           (inst_addr_i),
    .pdec_i         (pdec),
    .taken_i        (gs_taken),
    .ras_top_i      (ras_top),
    .ras_empty_i    (ras_empty),
    .stall_i        (ram_stall),
    .bpu_pc_o       (bpu_pc_o),
    .bpu_pc_valid_o (bpu_pc_valid_o),
    .ras_pop_o      (ras_pop)
  );

  // execute compares this against the resolved direction
  assign pred_o.taken   = bpu_pc_valid_o;
  assign pred_o.history = gs_history;

endmodule

/* hw/gshare_predictor.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module gshare_predictor (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic [`XLEN-1:0]       pc_i,
  input  fetch_pkg::bp_update_t  update_i,
  input  logic                   stall_i,  // execute stall, no training
  output logic                   taken_o,
  output logic [`HISLEN-1:0]     history_o
);

  localparam int IDX_W = $clog2(`BHT_ENTRIES);

  logic [1:0]         bht [`BHT_ENTRIES];
  logic [`HISLEN-1:0] history;
  logic [IDX_W-1:0]   lookup_idx;
  logic [IDX_W-1:0]   upd_idx;
  logic [1:0]         upd_cnt;
  logic               train;

  // word address bits xor'd with recent history
  assign lookup_idx = pc_i[IDX_W+1:2] ^ history[IDX_W-1:0];

  // training uses the history that was live when this branch was predicted
  assign upd_idx = update_i.pc[IDX_W+1:2] ^ update_i.history[IDX_W-1:0];
  assign upd_cnt = bht[upd_idx];

  // only conditional branches train, jumps are always taken anyway
  assign train = update_i.valid && (update_i.kind == fetch_pkg::JK_BRANCH) && !stall_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      history <= '0;
      for (int i = 0; i < `BHT_ENTRIES; i++) begin
        bht[i] <= 2'b01; // weakly not taken
      end
    end else if (train) begin
      history <= {history[`HISLEN-2:0], update_i.taken};
      if (update_i.taken) begin
        if (upd_cnt != 2'b11) begin
          bht[upd_idx] <= upd_cnt + 2'd1;
        end
      end else begin
        if (upd_cnt != 2'b00) begin
          bht[upd_idx] <= upd_cnt - 2'd1;
        end
      end
    end
  end

  assign taken_o   = bht[lookup_idx][1]; // msb of the counter
  assign history_o = history;

  // execute must report branches at word aligned pcs, else the index is off
  branch_update_aligned_a : assert property (
    @(posedge clk) disable iff (rst_i)
    (update_i.valid && update_i.kind == fetch_pkg::JK_BRANCH) |-> (update_i.pc[1:0] == 2'b00)
  );

endmodule

/* hw/next_pc_select.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module next_pc_select (
  input  logic                  [`XLEN-1:0] pc_i,
  input  fetch_pkg::predecode_t pdec_i,
  input  logic                  taken_i,      // gshare direction
  input  logic                  [`XLEN-1:0] ras_top_i,
  input  logic                  ras_empty_i,
  input  logic                  stall_i,      // fetch data not valid
  output logic                  [`XLEN-1:0] bpu_pc_o,
  output logic                  bpu_pc_valid_o,
  output logic                  ras_pop_o
);

  always_comb begin
    bpu_pc_o       = pc_i + `XLEN'd4; // fall through
    bpu_pc_valid_o = 1'b0;
    ras_pop_o      = 1'b0;
    if (!stall_i) begin
      case (pdec_i.kind)
        fetch_pkg::JK_JAL: begin
          bpu_pc_o       = pdec_i.target;
          bpu_pc_valid_o = 1'b1;
        end
        fetch_pkg::JK_BRANCH: begin
          if (taken_i) begin
            bpu_pc_o       = pdec_i.target;
            bpu_pc_valid_o = 1'b1;
          end
        end
        fetch_pkg::JK_JALR: begin
          // only returns are predictable without rs1
          if (pdec_i.is_return && !ras_empty_i) begin
            bpu_pc_o       = ras_top_i;
            bpu_pc_valid_o = 1'b1;
            ras_pop_o      = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

/* hw/return_stack.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module return_stack (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             push_i,       // call seen in decode
  input  logic [`XLEN-1:0] push_addr_i,
  input  logic             pop_i,        // return predicted in fetch
  output logic [`XLEN-1:0] top_o,
  output logic             empty_o
);

  localparam int PTR_W = $clog2(`RAS_DEPTH);
  localparam int CNT_W = $clog2(`RAS_DEPTH + 1);

  logic [`XLEN-1:0] stack [`RAS_DEPTH];
  logic [PTR_W-1:0] ptr;   // slot of the top entry
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ptr   <= '0;
      count <= '0;
    end else if (push_i && pop_i) begin
      // return and call together, top is swapped in place
    end else if (push_i) begin
      ptr <= ptr + 1'b1; // wraps onto the oldest when full
      if (count != CNT_W'(`RAS_DEPTH)) begin
        count <= count + 1'b1;
      end
    end else if (pop_i) begin
      ptr   <= ptr - 1'b1;
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i && pop_i) begin
      stack[ptr] <= push_addr_i;
    end else if (push_i) begin
      stack[ptr + 1'b1] <= push_addr_i;
    end
  end

  assign top_o   = stack[ptr];
  assign empty_o = (count == '0);

  // next_pc_select must gate pops with empty
  no_pop_when_empty_a : assert property (
    @(posedge clk) disable iff (rst_i) pop_i |-> !empty_o
  );

endmodule

/* tb/fetch_unit_tb.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_unit_tb;

  localparam int PERIOD = 4;
  localparam int N_ROWS = 32;
  localparam int N_RAND = 200;

  localparam logic [31:0] NOP   = 32'h00000013; // addi x0, x0, 0
  localparam logic [31:0] JAL16 = 32'h010000ef; // jal ra, +16
  localparam logic [31:0] JALM4 = 32'hffdff06f; // jal x0, -4
  localparam logic [31:0] JALR  = 32'h000100e7; // jalr ra, 0(sp)
  localparam logic [31:0] RET   = 32'h00008067; // jalr x0, 0(ra)
  localparam logic [31:0] BEQ8  = 32'h00000463; // beq x0, x0, +8

  typedef struct packed {
    logic [`XLEN-1:0]      addr;
    logic [`XLEN-1:0]      inst;
    logic                  valid;
    logic                  err;
    fetch_pkg::bp_update_t upd;
    logic                  ex_stall;
    logic                  push;
    logic [`XLEN-1:0]      push_addr;
    logic [`XLEN-1:0]      exp_pc;
    logic                  exp_valid;
    logic [`HISLEN-1:0]    exp_hist;
  } row_t;

  logic                   clk;
  logic                   rst_i;
  logic [`XLEN-1:0]       inst_addr_i;
  logic [`XLEN-1:0]       if_rdata_i;
  logic                   if_rdata_valid_i;
  logic                   if_rerr_i;
  fetch_pkg::bp_update_t  update_i;
  logic                   ex_stall_i;
  logic                   ras_push_i;
  logic [`XLEN-1:0]       ras_push_addr_i;
  logic [`XLEN-1:0]       inst_addr_o;
  logic [`XLEN-1:0]       inst_data_o;
  logic [`TRAP_LEN-1:0]   trap_bus_o;
  logic                   ram_stall_o;
  logic [`XLEN-1:0]       bpu_pc_o;
  logic                   bpu_pc_valid_o;
  fetch_pkg::prediction_t pred_o;

  row_t   rows [N_ROWS];
  string  names [N_ROWS];
  int     n_rows;
  integer seed;

  fetch_unit fetch_unit_inst (.*);

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  task automatic add_row(input string name, input logic [31:0] addr, input logic [31:0] inst,
                         input logic valid, input logic err, input logic [31:0] exp_pc,
                         input logic exp_valid, input logic [7:0] exp_hist);
    row_t r;
    r = '0;
    r.addr      = addr;
    r.inst      = inst;
    r.valid     = valid;
    r.err       = err;
    r.exp_pc    = exp_pc;
    r.exp_valid = exp_valid;
    r.exp_hist  = exp_hist;
    names[n_rows] = name;
    rows[n_rows]  = r;
    n_rows++;
  endtask

  // attach execute or decode traffic to the last row
  task automatic set_update(input fetch_pkg::bp_update_t upd, input logic ex_stall);
    rows[n_rows-1].upd      = upd;
    rows[n_rows-1].ex_stall = ex_stall;
  endtask

  task automatic set_push(input logic [31:0] addr);
    rows[n_rows-1].push      = 1'b1;
    rows[n_rows-1].push_addr = addr;
  endtask

  function automatic fetch_pkg::bp_update_t br_update(input logic [31:0] pc,
                                                      input logic [7:0] hist, input logic taken);
    fetch_pkg::bp_update_t u;
    u.valid   = 1'b1;
    u.kind    = fetch_pkg::JK_BRANCH;
    u.taken   = taken;
    u.pc      = pc;
    u.history = hist;
    return u;
  endfunction

  function automatic logic [`TRAP_LEN-1:0] expected_trap(input row_t r);
    logic [`TRAP_LEN-1:0] t;
    t = '0;
    t[`TRAP_INST_ADDR_MISALIGNED] = (r.addr[1:0] != 2'b00);
    t[`TRAP_INST_ACCESS_FAULT]    = r.valid && r.err; // fault only counts with data
    return t;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic drive_inputs(input row_t r);
    inst_addr_i      = r.addr;
    if_rdata_i       = r.inst;
    if_rdata_valid_i = r.valid;
    if_rerr_i        = r.err;
    update_i         = r.upd;
    ex_stall_i       = r.ex_stall;
    ras_push_i       = r.push;
    ras_push_addr_i  = r.push_addr;
  endtask

  task automatic check_fetch(input string name, input row_t r);
    check_value({name, " inst_addr"}, r.addr, inst_addr_o);
    check_value({name, " inst_data"}, r.inst, inst_data_o);
    check_value({name, " ram_stall"}, !r.valid, ram_stall_o);
    check_value({name, " trap_bus"}, expected_trap(r), trap_bus_o);
  endtask

  task automatic build_table();
    add_row("nop", 32'h1000, NOP, 1, 0, 32'h1004, 0, 8'h00);
    add_row("misaligned", 32'h1002, NOP, 1, 0, 32'h1006, 0, 8'h00);
    add_row("access fault", 32'h1008, NOP, 1, 1, 32'h100c, 0, 8'h00);
    add_row("fault without data", 32'h100c, NOP, 0, 1, 32'h1010, 0, 8'h00);
    add_row("jal forward", 32'h2000, JAL16, 1, 0, 32'h2010, 1, 8'h00);
    add_row("jal backward", 32'h2000, JALM4, 1, 0, 32'h1ffc, 1, 8'h00);
    add_row("plain jalr", 32'h2004, JALR, 1, 0, 32'h2008, 0, 8'h00);
    add_row("jal stalled", 32'h2000, JAL16, 0, 0, 32'h2004, 0, 8'h00);
    // push lands even while fetch is stalled
    add_row("push a stalled", 32'h3000, NOP, 0, 0, 32'h3004, 0, 8'h00);
    set_push(32'h1004);
    add_row("push b", 32'h3004, NOP, 1, 0, 32'h3008, 0, 8'h00);
    set_push(32'h2008);
    add_row("return stalled", 32'h3100, RET, 0, 0, 32'h3104, 0, 8'h00);
    add_row("return b", 32'h3100, RET, 1, 0, 32'h2008, 1, 8'h00);
    add_row("return a", 32'h3100, RET, 1, 0, 32'h1004, 1, 8'h00);
    add_row("return empty", 32'h3100, RET, 1, 0, 32'h3104, 0, 8'h00);
    for (int k = 0; k < 5; k++) begin
      add_row("push five", 32'h3200, NOP, 1, 0, 32'h3204, 0, 8'h00);
      set_push(32'h4000 + 4 * k);
    end
    for (int k = 4; k > 0; k--) begin
      add_row("return after overflow", 32'h3100, RET, 1, 0, 32'h4000 + 4 * k, 1, 8'h00);
    end
    add_row("return drained", 32'h3100, RET, 1, 0, 32'h3104, 0, 8'h00);
    // counter index 0x10 is the target of every update below
    add_row("branch cold", 32'h4c, BEQ8, 1, 0, 32'h50, 0, 8'h00);
    set_update(br_update(32'h40, 8'h00, 1), 0);
    add_row("second taken update", 32'h1000, NOP, 1, 0, 32'h1004, 0, 8'h01);
    set_update(br_update(32'h44, 8'h01, 1), 0);
    add_row("branch trained", 32'h4c, BEQ8, 1, 0, 32'h54, 1, 8'h03);
    set_update(br_update(32'h4c, 8'h03, 0), 1);
    add_row("ex stall ignored", 32'h4c, BEQ8, 1, 0, 32'h54, 1, 8'h03);
    set_update(br_update(32'h4c, 8'h03, 0), 0);
    add_row("not taken 2", 32'h1000, NOP, 1, 0, 32'h1004, 0, 8'h06);
    set_update(br_update(32'h58, 8'h06, 0), 0);
    add_row("not taken 3", 32'h1000, NOP, 1, 0, 32'h1004, 0, 8'h0c);
    set_update(br_update(32'h70, 8'h0c, 0), 0);
    add_row("not taken 4", 32'h1000, NOP, 1, 0, 32'h1004, 0, 8'h18);
    set_update(br_update(32'h20, 8'h18, 0), 0);
    add_row("branch untrained", 32'h80, BEQ8, 1, 0, 32'h84, 0, 8'h30);
  endtask

  initial begin
    row_t r;
    seed   = 32'heb3f2d8a;
    n_rows = 0;
    build_table();
    drive_inputs('0);
    rst_i = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      drive_inputs(rows[i]);
      #1; // combinational outputs settle well before the rising edge
      check_fetch(names[i], rows[i]);
      check_value({names[i], " bpu_pc"}, rows[i].exp_pc, bpu_pc_o);
      check_value({names[i], " bpu_pc_valid"}, rows[i].exp_valid, bpu_pc_valid_o);
      check_value({names[i], " pred taken"}, rows[i].exp_valid, pred_o.taken);
      check_value({names[i], " pred history"}, rows[i].exp_hist, pred_o.history);
      @(negedge clk);
    end
    // stack is empty here, so random words never pop
    for (int i = 0; i < N_RAND; i++) begin
      r       = '0;
      r.addr  = $random(seed);
      r.inst  = $random(seed);
      r.valid = $random(seed);
      r.err   = $random(seed);
      drive_inputs(r);
      #1;
      check_fetch("random", r);
      @(negedge clk);
    end
    $display("All checks passed");
    $finish;
  end

  initial begin
    #((N_ROWS + N_RAND + 20) * PERIOD);
    $display("timeout: the run did not finish in the expected time");
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

endmodule
